//--- Bender.yml
package:
  name: hwloop

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/hwloop_pkg.sv
      - rtl/hwloop_if.sv
      - rtl/hwloop_setup_decoder.sv
      - rtl/hwloop_reg_set.sv
      - rtl/hwloop_controller.sv
      - rtl/hwloop_unit.sv
  - target: simulation
    files:
      - sim/hwloop_tb.sv

//--- flist.f
+incdir+rtl
rtl/hwloop_pkg.sv
rtl/hwloop_if.sv
rtl/hwloop_setup_decoder.sv
rtl/hwloop_reg_set.sv
rtl/hwloop_controller.sv
rtl/hwloop_unit.sv
sim/hwloop_tb.sv

//--- rtl/hwloop_controller.sv
// loop controller: matches the issued pc against all loop ends and picks the jump target
`include "hwloop_params.svh"

module hwloop_controller (
  // used only by the request check
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // pc issued by the decode stage
  input  logic [`HWLP_ADDR_W-1:0] pc_i,
  input  logic                    pc_valid_i,
  // all loop register sets
  hwlp_loop_if.ctrl               loop_i [`HWLP_N_REGS],
  // jump order to fetch
  output logic                    jump_o,
  output logic [`HWLP_ADDR_W-1:0] target_o
);

  localparam int CNT_W = `HWLP_CNT_W;

  // loop k wants to jump back
  logic [`HWLP_N_REGS-1:0]                    hit;
  logic [`HWLP_N_REGS-1:0][`HWLP_ADDR_W-1:0] start_addr;
  logic [`HWLP_N_REGS-1:0]                    dec_req;
  logic                                       sel_found;

  ////////////////////////////////////////////////////////////
  // end address comparators
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `HWLP_N_REGS; g++) begin : gen_cmp
    logic [`HWLP_CNT_W-1:0] cnt;

    assign cnt           = loop_i[g].counter;
    assign start_addr[g] = loop_i[g].start_addr;
    assign loop_i[g].dec_req = dec_req[g];

    always_comb begin
      hit[g] = 1'b0;
      if (pc_valid_i && (pc_i == loop_i[g].end_addr)) begin
        if (|cnt[CNT_W-1:2]) begin
          hit[g] = 1'b1;
        end else begin
          case (cnt[1:0])
            2'b11:   hit[g] = 1'b1;
            // last jump only when no decrement is in flight
            2'b10:   hit[g] = ~loop_i[g].dec_pending;
            default: hit[g] = 1'b0;
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // fixed priority select, lowest index wins
  ////////////////////////////////////////////////////////////

  always_comb begin
    target_o  = '0;
    dec_req   = '0;
    sel_found = 1'b0;
    for (int k = 0; k < `HWLP_N_REGS; k++) begin
      if (hit[k] && !sel_found) begin
        target_o   = start_addr[k];
        dec_req[k] = 1'b1;
        sel_found  = 1'b1;
      end
    end
  end

  assign jump_o = |hit;

  // at most one loop is decremented, and only together with a jump
  dec_onehot_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(dec_req) && ((|dec_req) == jump_o)
  );

endmodule

//--- rtl/hwloop_if.sv
// per-loop link between one loop register set and the loop controller
`include "hwloop_params.svh"

interface hwlp_loop_if;

  ////////////////////////////////////////////////////////////
  // register contents seen by the controller
  ////////////////////////////////////////////////////////////

  // first instruction of the loop body
  logic [`HWLP_ADDR_W-1:0] start_addr;
  // last instruction of the loop body
  logic [`HWLP_ADDR_W-1:0] end_addr;
  // iterations left, including the one running
  logic [`HWLP_CNT_W-1:0]  counter;
  // a decrement was ordered but has not reached the counter yet
  logic                    dec_pending;

  ////////////////////////////////////////////////////////////
  // request back to the register set
  ////////////////////////////////////////////////////////////

  // one cycle strobe, the controller took a jump for this loop
  logic                    dec_req;

  // register side
  modport regs (
    output start_addr, end_addr, counter, dec_pending,
    input  dec_req
  );

  // controller side
  modport ctrl (
    input  start_addr, end_addr, counter, dec_pending,
    output dec_req
  );

endinterface

//--- rtl/hwloop_params.svh
// hardware loop sizing: number of loop register sets, address and counter widths
`ifndef HWLOOP_PARAMS_SVH
`define HWLOOP_PARAMS_SVH

////////////////////////////////////////////////////////////
// loop register sets
////////////////////////////////////////////////////////////

// number of independent loop register sets
`define HWLP_N_REGS 2

// width of the loop select field in a setup command
`define HWLP_IDX_W (((`HWLP_N_REGS) > 1) ? $clog2(`HWLP_N_REGS) : 1)

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// pc and loop address width
`define HWLP_ADDR_W 32
// iteration counter width
`define HWLP_CNT_W 32

`endif

//--- rtl/hwloop_pkg.sv
// hardware loop types shared by the setup decoder and the top level
package hwloop_pkg;

  ////////////////////////////////////////////////////////////
  // setup command opcodes
  ////////////////////////////////////////////////////////////

  // opcode issued by the decode stage together with cmd_valid
  // values above SETUP are reserved and decode to no write
  typedef enum logic [2:0] {
    // no register is touched
    HWLP_OP_NONE  = 3'd0,
    // start address taken from the data word
    HWLP_OP_START = 3'd1,
    // end address taken from the data word
    HWLP_OP_END   = 3'd2,
    // iteration count taken from the data word
    HWLP_OP_COUNT = 3'd3,
    // full setup in one command
    // start = pc + 4, end = pc + data, counter = count input
    HWLP_OP_SETUP = 3'd4
  } hwlp_op_e;

endpackage

//--- rtl/hwloop_reg_set.sv
// one loop register set: start, end and counter with a decrement delayed by one edge
`include "hwloop_params.svh"

module hwloop_reg_set (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // write strobes for this loop
  input  logic                    wr_start_i,
  input  logic                    wr_end_i,
  input  logic                    wr_cnt_i,
  // shared write values
  input  logic [`HWLP_ADDR_W-1:0] start_val_i,
  input  logic [`HWLP_ADDR_W-1:0] end_val_i,
  input  logic [`HWLP_CNT_W-1:0]  cnt_val_i,
  // view towards the controller
  hwlp_loop_if.regs               loop_o
);

  localparam int CNT_W = `HWLP_CNT_W;

  logic [`HWLP_ADDR_W-1:0] start_q;
  logic [`HWLP_ADDR_W-1:0] end_q;
  logic [`HWLP_CNT_W-1:0]  cnt_q;
  // decrement accepted, counter update follows at the next edge
  logic                    pend_q;

  ////////////////////////////////////////////////////////////
  // address registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_q <= '0;
      end_q   <= '0;
    end else begin
      if (wr_start_i) begin
        start_q <= start_val_i;
      end
      if (wr_end_i) begin
        end_q <= end_val_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // counter with two-stage decrement
  ////////////////////////////////////////////////////////////

  // request in cycle t sets the flag at the end of t,
  // the counter drops one edge later.
  // back to back requests keep the flag set and decrement every edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      pend_q <= 1'b0;
    end else if (wr_cnt_i) begin
      // a new count overrides anything in flight
      cnt_q  <= cnt_val_i;
      pend_q <= 1'b0;
    end else begin
      if (pend_q) begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
      pend_q <= loop_o.dec_req;
    end
  end

  assign loop_o.start_addr  = start_q;
  assign loop_o.end_addr    = end_q;
  assign loop_o.counter     = cnt_q;
  assign loop_o.dec_pending = pend_q;

  // controller only jumps while at least two iterations remain
  no_dec_below_two_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    loop_o.dec_req |-> (cnt_q >= CNT_W'(2))
  );

endmodule

//--- rtl/hwloop_setup_decoder.sv
// loop setup decoder: turns one setup command into per-loop write strobes and values
`include "hwloop_params.svh"

module hwloop_setup_decoder (
  // used only by the range check
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  // setup command from the decode stage
  input  logic                        cmd_valid_i,
  input  hwloop_pkg::hwlp_op_e        cmd_op_i,
  input  logic [`HWLP_IDX_W-1:0]      cmd_loop_i,
  input  logic [`HWLP_ADDR_W-1:0]     cmd_data_i,
  input  logic [`HWLP_CNT_W-1:0]      cmd_count_i,
  input  logic [`HWLP_ADDR_W-1:0]     cmd_pc_i,
  // per-loop write strobes
  output logic [`HWLP_N_REGS-1:0]     wr_start_o,
  output logic [`HWLP_N_REGS-1:0]     wr_end_o,
  output logic [`HWLP_N_REGS-1:0]     wr_cnt_o,
  // write values shared by all loops
  output logic [`HWLP_ADDR_W-1:0]     start_val_o,
  output logic [`HWLP_ADDR_W-1:0]     end_val_o,
  output logic [`HWLP_CNT_W-1:0]      cnt_val_o
);

  localparam int ADDR_W = `HWLP_ADDR_W;
  localparam int CNT_W  = `HWLP_CNT_W;

  // one-hot select of the addressed loop, empty when idle
  logic [`HWLP_N_REGS-1:0] loop_sel;

  always_comb begin
    loop_sel = '0;
    if (cmd_valid_i && (cmd_loop_i < `HWLP_N_REGS)) begin
      loop_sel[cmd_loop_i] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    wr_start_o  = '0;
    wr_end_o    = '0;
    wr_cnt_o    = '0;
    // single writes take the raw data word
    start_val_o = cmd_data_i;
    end_val_o   = cmd_data_i;
    cnt_val_o   = CNT_W'(cmd_data_i);

    case (cmd_op_i)
      hwloop_pkg::HWLP_OP_START: wr_start_o = loop_sel;
      hwloop_pkg::HWLP_OP_END:   wr_end_o   = loop_sel;
      hwloop_pkg::HWLP_OP_COUNT: wr_cnt_o   = loop_sel;
      hwloop_pkg::HWLP_OP_SETUP: begin
        wr_start_o  = loop_sel;
        wr_end_o    = loop_sel;
        wr_cnt_o    = loop_sel;
        // body starts right after the setup instruction
        start_val_o = cmd_pc_i + ADDR_W'(4);
        // end is an offset from the setup instruction
        end_val_o   = cmd_pc_i + cmd_data_i;
        cnt_val_o   = cmd_count_i;
      end
      default: ;
    endcase
  end

  // the decode stage never addresses a loop set that does not exist
  loop_idx_in_range_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cmd_valid_i |-> (cmd_loop_i < `HWLP_N_REGS)
  );

endmodule

//--- rtl/hwloop_unit.sv
// hardware loop unit top: setup decoder, loop register sets and loop controller
`include "hwloop_params.svh"

module hwloop_unit (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // loop setup command
  input  logic                    cmd_valid_i,
  input  hwloop_pkg::hwlp_op_e    cmd_op_i,
  input  logic [`HWLP_IDX_W-1:0]  cmd_loop_i,
  input  logic [`HWLP_ADDR_W-1:0] cmd_data_i,
  input  logic [`HWLP_CNT_W-1:0]  cmd_count_i,
  input  logic [`HWLP_ADDR_W-1:0] cmd_pc_i,
  // issued pc
  input  logic [`HWLP_ADDR_W-1:0] pc_i,
  input  logic                    pc_valid_i,
  // jump back to the loop start
  output logic                    jump_o,
  output logic [`HWLP_ADDR_W-1:0] target_o
);

  // decoder to register sets
  logic [`HWLP_N_REGS-1:0] wr_start;
  logic [`HWLP_N_REGS-1:0] wr_end;
  logic [`HWLP_N_REGS-1:0] wr_cnt;
  logic [`HWLP_ADDR_W-1:0] start_val;
  logic [`HWLP_ADDR_W-1:0] end_val;
  logic [`HWLP_CNT_W-1:0]  cnt_val;

  // register sets to controller
  hwlp_loop_if loop_if [`HWLP_N_REGS] ();

  hwloop_setup_decoder u_decoder (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_loop_i  (cmd_loop_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_count_i (cmd_count_i),
    .cmd_pc_i    (cmd_pc_i),
    .wr_start_o  (wr_start),
    .wr_end_o    (wr_end),
    .wr_cnt_o    (wr_cnt),
    .start_val_o (start_val),
    .end_val_o   (end_val),
    .cnt_val_o   (cnt_val)
  );

  ////////////////////////////////////////////////////////////
  // loop register sets
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < `HWLP_N_REGS; g++) begin : gen_regs
    hwloop_reg_set u_regs (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .wr_start_i  (wr_start[g]),
      .wr_end_i    (wr_end[g]),
      .wr_cnt_i    (wr_cnt[g]),
      .start_val_i (start_val),
      .end_val_i   (end_val),
      .cnt_val_i   (cnt_val),
      .loop_o      (loop_if[g])
    );
  end

  hwloop_controller u_ctrl (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .pc_i       (pc_i),
    .pc_valid_i (pc_valid_i),
    .loop_i     (loop_if),
    .jump_o     (jump_o),
    .target_o   (target_o)
  );

endmodule

//--- sim/hwloop_tb.sv
// hardware loop unit testbench: table of setup commands and pc issues against a register model
`include "hwloop_params.svh"

module hwloop_tb;

  localparam int N_REGS = `HWLP_N_REGS;
  localparam int IDX_W  = `HWLP_IDX_W;
  localparam int ADDR_W = `HWLP_ADDR_W;
  localparam int CNT_W  = `HWLP_CNT_W;

  // one table row is one clock cycle of stimulus
  typedef struct packed {
    logic                 cmd_valid;
    hwloop_pkg::hwlp_op_e op;
    logic [IDX_W-1:0]     loop;
    logic [ADDR_W-1:0]    data;
    logic [CNT_W-1:0]     count;
    logic [ADDR_W-1:0]    cmd_pc;
    logic [ADDR_W-1:0]    pc;
    logic                 pc_valid;
    // test section, used for the per-section jump counts
    logic [2:0]           tag;
  } row_t;

  logic                 clk_i;
  logic                 arst_n_i;
  logic                 cmd_valid_i;
  hwloop_pkg::hwlp_op_e cmd_op_i;
  logic [IDX_W-1:0]     cmd_loop_i;
  logic [ADDR_W-1:0]    cmd_data_i;
  logic [CNT_W-1:0]     cmd_count_i;
  logic [ADDR_W-1:0]    cmd_pc_i;
  logic [ADDR_W-1:0]    pc_i;
  logic                 pc_valid_i;
  logic                 jump_o;
  logic [ADDR_W-1:0]    target_o;

  row_t        rows[$];
  logic [2:0]  section;
  logic [31:0] rng;
  int          errors;
  int          checks;
  int          cycles;
  int          jumps_by_tag [8];

  // reference copy of the loop registers
  logic [ADDR_W-1:0] m_start [N_REGS];
  logic [ADDR_W-1:0] m_end   [N_REGS];
  logic [CNT_W-1:0]  m_cnt   [N_REGS];
  logic              m_pend  [N_REGS];
  // model outputs for the current row
  logic              exp_jump;
  logic [ADDR_W-1:0] exp_target;
  logic [N_REGS-1:0] exp_dec;

  hwloop_unit dut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_op_i    (cmd_op_i),
    .cmd_loop_i  (cmd_loop_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_count_i (cmd_count_i),
    .cmd_pc_i    (cmd_pc_i),
    .pc_i        (pc_i),
    .pc_valid_i  (pc_valid_i),
    .jump_o      (jump_o),
    .target_o    (target_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // table building
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic put_row(input logic cv, input hwloop_pkg::hwlp_op_e op, input int lp,
                         input logic [31:0] data, input logic [31:0] count,
                         input logic [31:0] cmd_pc, input logic [31:0] pc, input logic pv);
    row_t r;
    r.cmd_valid = cv;
    r.op        = op;
    r.loop      = IDX_W'(lp);
    r.data      = data;
    r.count     = count;
    r.cmd_pc    = cmd_pc;
    r.pc        = pc;
    r.pc_valid  = pv;
    r.tag       = section;
    rows.push_back(r);
  endtask

  // full setup: start = pc + 4, end = pc + offset
  task automatic setup_cmd(input int lp, input logic [31:0] offs, input logic [31:0] count,
                           input logic [31:0] pc);
    put_row(1'b1, hwloop_pkg::HWLP_OP_SETUP, lp, offs, count, pc, 32'h0, 1'b0);
  endtask

  task automatic write_cmd(input hwloop_pkg::hwlp_op_e op, input int lp,
                           input logic [31:0] data);
    put_row(1'b1, op, lp, data, 32'h0, 32'h0, 32'h0, 1'b0);
  endtask

  task automatic issue_at(input logic [31:0] pc);
    put_row(1'b0, hwloop_pkg::HWLP_OP_NONE, 0, 32'h0, 32'h0, 32'h0, pc, 1'b1);
  endtask

  task automatic idle(input int n);
    repeat (n) put_row(1'b0, hwloop_pkg::HWLP_OP_NONE, 0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0);
  endtask

  // random noise on every field, but no command and no valid pc
  task automatic fillers(input int n);
    logic [31:0] a;
    logic [31:0] b;
    repeat (n) begin
      rng = xorshift32(rng);
      a   = rng;
      rng = xorshift32(rng);
      b   = rng;
      put_row(1'b0, hwloop_pkg::hwlp_op_e'({1'b0, a[1:0]}), int'(a[2]), a, b, ~a, b, 1'b0);
    end
  endtask

  task automatic build_table;
    // after reset every end address is zero and every counter too
    section = 3'd1;
    issue_at(32'h0000_0000);
    issue_at(32'h0000_0100);
    issue_at(32'h0000_0004);
    fillers(4);
    // count 4, issues three cycles apart
    section = 3'd2;
    setup_cmd(0, 32'h20, 32'd4, 32'h0000_1000);
    repeat (5) begin
      issue_at(32'h0000_1020);
      idle(2);
    end
    fillers(3);
    // back to back issues hit the in-flight rule
    section = 3'd3;
    setup_cmd(1, 32'h10, 32'd3, 32'h0000_2000);
    idle(1);
    repeat (5) issue_at(32'h0000_2010);
    setup_cmd(0, 32'h08, 32'd2, 32'h0000_2100);
    repeat (3) issue_at(32'h0000_2108);
    fillers(3);
    // shared end address, loop 1 ends where loop 0 ends
    section = 3'd4;
    setup_cmd(0, 32'h40, 32'd3, 32'h0000_3000);
    setup_cmd(1, 32'hFFFF_FF40, 32'd5, 32'h0000_3100);
    repeat (6) begin
      issue_at(32'h0000_3040);
      idle(2);
    end
    fillers(3);
    // single writes, visible in the next cycle
    section = 3'd5;
    write_cmd(hwloop_pkg::HWLP_OP_START, 1, 32'h0000_4000);
    write_cmd(hwloop_pkg::HWLP_OP_COUNT, 1, 32'd10);
    write_cmd(hwloop_pkg::HWLP_OP_END, 1, 32'h0000_4080);
    issue_at(32'h0000_4080);
    // count write lands on the edge that applies the decrement
    write_cmd(hwloop_pkg::HWLP_OP_COUNT, 1, 32'd2);
    put_row(1'b0, hwloop_pkg::HWLP_OP_NONE, 0, 32'h0, 32'h0, 32'h0, 32'h0000_4080, 1'b0);
    issue_at(32'h0000_4084);
    write_cmd(hwloop_pkg::HWLP_OP_NONE, 1, 32'h0000_5000);
    issue_at(32'h0000_4080);
    idle(2);
    issue_at(32'h0000_4080);
    idle(2);
  endtask

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // fixed priority, lowest loop index with a qualifying counter wins
  task automatic predict_jump(input row_t r);
    exp_jump   = 1'b0;
    exp_target = '0;
    exp_dec    = '0;
    for (int k = 0; k < N_REGS; k++) begin
      if (!exp_jump && r.pc_valid && (r.pc == m_end[k])) begin
        if ((m_cnt[k] >= 3) || ((m_cnt[k] == 2) && !m_pend[k])) begin
          exp_jump   = 1'b1;
          exp_target = m_start[k];
          exp_dec[k] = 1'b1;
        end
      end
    end
  endtask

  // state after the edge that ends the current row
  task automatic advance_model(input row_t r);
    logic sel;
    logic setup;
    for (int k = 0; k < N_REGS; k++) begin
      sel   = r.cmd_valid && (int'(r.loop) == k);
      setup = (r.op == hwloop_pkg::HWLP_OP_SETUP);
      if (sel && (setup || (r.op == hwloop_pkg::HWLP_OP_START))) begin
        m_start[k] = setup ? r.cmd_pc + 32'd4 : r.data;
      end
      if (sel && (setup || (r.op == hwloop_pkg::HWLP_OP_END))) begin
        m_end[k] = setup ? r.cmd_pc + r.data : r.data;
      end
      if (sel && (setup || (r.op == hwloop_pkg::HWLP_OP_COUNT))) begin
        // counter write beats the decrement and drops it
        m_cnt[k]  = setup ? r.count : r.data;
        m_pend[k] = 1'b0;
      end else begin
        if (m_pend[k]) begin
          m_cnt[k] = m_cnt[k] - 1;
        end
        m_pend[k] = exp_dec[k];
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    arst_n_i    = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_op_i    = hwloop_pkg::HWLP_OP_NONE;
    cmd_loop_i  = '0;
    cmd_data_i  = '0;
    cmd_count_i = '0;
    cmd_pc_i    = '0;
    pc_i        = '0;
    pc_valid_i  = 1'b0;
    errors      = 0;
    checks      = 0;
    cycles      = 0;
    rng         = 32'd40;
    for (int k = 0; k < 8; k++) begin
      jumps_by_tag[k] = 0;
    end
    for (int k = 0; k < N_REGS; k++) begin
      m_start[k] = '0;
      m_end[k]   = '0;
      m_cnt[k]   = '0;
      m_pend[k]  = 1'b0;
    end
    build_table();

    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;

    foreach (rows[i]) begin
      @(posedge clk_i);
      cmd_valid_i <= rows[i].cmd_valid;
      cmd_op_i    <= rows[i].op;
      cmd_loop_i  <= rows[i].loop;
      cmd_data_i  <= rows[i].data;
      cmd_count_i <= rows[i].count;
      cmd_pc_i    <= rows[i].cmd_pc;
      pc_i        <= rows[i].pc;
      pc_valid_i  <= rows[i].pc_valid;
      // outputs are settled half a period later
      @(negedge clk_i);
      predict_jump(rows[i]);
      checks++;
      if (jump_o !== exp_jump) begin
        $display("FAILED t=%0t row %0d jump_o: got %b, expected %b",
                 $time, i, jump_o, exp_jump);
        errors++;
      end
      if (exp_jump && (target_o !== exp_target)) begin
        $display("FAILED t=%0t row %0d target_o: got %h, expected %h",
                 $time, i, target_o, exp_target);
        errors++;
      end
      if (jump_o === 1'b1) begin
        jumps_by_tag[rows[i].tag]++;
      end
      advance_model(rows[i]);
    end

    // count of 4 with spaced issues leaves three jumps
    if (jumps_by_tag[2] != 3) begin
      $display("loop with count 4 jumped %0d times instead of 3", jumps_by_tag[2]);
      errors++;
    end
    if (jumps_by_tag[1] != 0) begin
      $display("jump seen right after reset");
      errors++;
    end

    @(posedge clk_i);
    pc_valid_i  <= 1'b0;
    cmd_valid_i <= 1'b0;
    $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog counts cycles from reset release
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      cycles++;
      if (cycles > rows.size() + 40) begin
        $display("timeout: run did not end within %0d cycles", rows.size() + 40);
        $display("Result: FAILED");
        $finish;
      end
    end
  end

endmodule
